//--- logic/audio_cfg.svh
// Build-time sizing for the whole audio path; AUDIO_SAMPLE_W is also the I2S slot length
`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// Converter code width, offset binary
`define AUDIO_ADC_W 12

// Signed sample width and bits per I2S slot
`define AUDIO_SAMPLE_W 16

// Gain in Q2.8, so 256 means unity
`define AUDIO_GAIN_W 10
`define AUDIO_GAIN_FRAC 8

// Clock division, in clk cycles per half period
`define AUDIO_BCLK_HALF 2
`define AUDIO_MCLK_HALF 1

`endif

//--- logic/audio_pkg.sv
// Types for the audio path; widths follow audio_cfg.svh and must not be changed here
`include "audio_cfg.svh"

package audio_pkg;

	// Raw converter output, unsigned offset binary
	typedef logic [`AUDIO_ADC_W-1:0] adc_code_t;

	// Two's complement audio sample
	typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

	// Unsigned Q2.8 gain
	typedef logic [`AUDIO_GAIN_W-1:0] gain_t;

	// One sample moving forward, no back-pressure
	typedef struct packed {
		logic    valid;
		sample_t sample;
	} sample_beat_t;

	typedef enum logic {
		WAIT_REQ,  // Idle until the controller raises req
		WAIT_DROP  // Ack held high until req falls
	} cap_state_t;

	typedef enum logic {
		IDLE,
		SHIFT
	} i2s_state_t;

endpackage

//--- logic/sample_capture.sv
// The controller must hold adc_code stable while adc_req is high and raise req only after ack falls
`timescale 1ns/1ps
`include "audio_cfg.svh"

module sample_capture import audio_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         adc_req,
	input  adc_code_t    adc_code,
	output logic         adc_ack,
	output sample_beat_t beat
);

	localparam int PAD_W = `AUDIO_SAMPLE_W - `AUDIO_ADC_W;

	cap_state_t state;
	logic       beat_valid;
	sample_t    beat_sample;
	sample_t    code_signed;

	// Flip the MSB to get two's complement, then left justify
	assign code_signed = {~adc_code[`AUDIO_ADC_W-1], adc_code[`AUDIO_ADC_W-2:0], {PAD_W{1'b0}}};

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= WAIT_REQ;
			adc_ack    <= 1'b0;
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= 1'b0; // Single-cycle pulse
			case (state)
				WAIT_REQ: begin
					if (adc_req) begin
						state      <= WAIT_DROP;
						adc_ack    <= 1'b1;
						beat_valid <= 1'b1; // Same cycle as ack rise
					end
				end
				WAIT_DROP: begin
					if (!adc_req) begin
						state   <= WAIT_REQ;
						adc_ack <= 1'b0;
					end
				end
				default: state <= WAIT_REQ;
			endcase
		end
	end

	// Payload taken on the req rise only
	always_ff @(posedge clk) begin
		if (state == WAIT_REQ && adc_req)
			beat_sample <= code_signed;
	end

	assign beat = '{valid: beat_valid, sample: beat_sample};

endmodule

//--- logic/gain_stage.sv
// Fixed two-cycle latency in both gain and bypass mode; gain and bypass are sampled with each beat
`timescale 1ns/1ps
`include "audio_cfg.svh"

module gain_stage import audio_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  sample_beat_t beat_in,
	input  gain_t        gain,
	input  logic         bypass,
	output sample_beat_t beat_out
);

	// Signed sample times a zero-extended gain
	localparam int PROD_W = `AUDIO_SAMPLE_W + `AUDIO_GAIN_W + 1;

	localparam logic signed [PROD_W-1:0] SAT_MAX = (2 ** (`AUDIO_SAMPLE_W - 1)) - 1;
	localparam logic signed [PROD_W-1:0] SAT_MIN = -(2 ** (`AUDIO_SAMPLE_W - 1));

	logic signed [PROD_W-1:0] prod;
	logic signed [PROD_W-1:0] scaled;
	sample_t                  clamped;

	// Stage one registers
	logic                     s1_valid;
	logic signed [PROD_W-1:0] s1_prod;
	sample_t                  s1_raw;
	logic                     s1_bypass;

	// Stage two registers
	logic    s2_valid;
	sample_t s2_sample;

	assign prod = beat_in.sample * $signed({1'b0, gain});

	// Arithmetic shift floors toward minus infinity
	assign scaled = s1_prod >>> `AUDIO_GAIN_FRAC;

	always_comb begin
		if (scaled > SAT_MAX)
			clamped = SAT_MAX[`AUDIO_SAMPLE_W-1:0];
		else if (scaled < SAT_MIN)
			clamped = SAT_MIN[`AUDIO_SAMPLE_W-1:0];
		else
			clamped = scaled[`AUDIO_SAMPLE_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= beat_in.valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_prod   <= prod;
		s1_raw    <= beat_in.sample;
		s1_bypass <= bypass;
		s2_sample <= s1_bypass ? s1_raw : clamped; // Raw path keeps the same latency
	end

	assign beat_out = '{valid: s2_valid, sample: s2_sample};

endmodule

//--- logic/i2s_transmitter.sv
// Standard I2S master with both slots carrying the newest sample; the first frame after reset is zero
`timescale 1ns/1ps
`include "audio_cfg.svh"

module i2s_transmitter import audio_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  sample_beat_t beat,
	output logic         mclk,
	output logic         bclk,
	output logic         lrclk,
	output logic         sdata
);

	localparam int FRAME_BITS = 2 * `AUDIO_SAMPLE_W;
	localparam int POS_W      = $clog2(FRAME_BITS);
	localparam int MCNT_W     = $clog2(`AUDIO_MCLK_HALF + 1);
	localparam int BCNT_W     = $clog2(`AUDIO_BCLK_HALF + 1);

	localparam logic [MCNT_W-1:0] MCNT_LAST = MCNT_W'(`AUDIO_MCLK_HALF - 1);
	localparam logic [BCNT_W-1:0] BCNT_LAST = BCNT_W'(`AUDIO_BCLK_HALF - 1);
	localparam logic [POS_W-1:0]  POS_LAST  = POS_W'(FRAME_BITS - 1);

	i2s_state_t state;

	logic [MCNT_W-1:0]     mclk_cnt;
	logic [BCNT_W-1:0]     bclk_cnt;
	logic [POS_W-1:0]      bit_pos;  // Position in the frame, steps on falling bclk
	logic [POS_W-1:0]      bit_next;
	logic                  bclk_fall;
	sample_t               hold;
	logic [FRAME_BITS-1:0] shreg;

	assign bclk_fall = bclk && (bclk_cnt == BCNT_LAST);
	assign bit_next  = bit_pos + 1'b1;

	// Newest sample wins
	always_ff @(posedge clk) begin
		if (rst)
			hold <= '0;
		else if (beat.valid)
			hold <= beat.sample;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			mclk_cnt <= '0;
			mclk     <= 1'b0;
			bclk_cnt <= '0;
			bclk     <= 1'b0;
			lrclk    <= 1'b0;
			bit_pos  <= '0;
		end else begin
			case (state)
				IDLE: begin
					state   <= SHIFT; // First frame begins here with lrclk low
					bit_pos <= '0;
				end
				SHIFT: begin
					if (mclk_cnt == MCNT_LAST) begin
						mclk_cnt <= '0;
						mclk     <= ~mclk;
					end else begin
						mclk_cnt <= mclk_cnt + 1'b1;
					end

					if (bclk_cnt == BCNT_LAST) begin
						bclk_cnt <= '0;
						bclk     <= ~bclk;
					end else begin
						bclk_cnt <= bclk_cnt + 1'b1;
					end

					if (bclk_fall) begin
						bit_pos <= bit_next;
						lrclk   <= (bit_next >= POS_W'(`AUDIO_SAMPLE_W)); // Right slot high
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Data path
	always_ff @(posedge clk) begin
		if (rst) begin
			sdata <= 1'b0;
		end else if (state == IDLE) begin
			sdata <= 1'b0;
		end else if (bclk_fall) begin
			sdata <= shreg[FRAME_BITS-1]; // LSB of the right slot wraps into the frame start
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE)
			shreg <= {hold, hold};
		else if (bclk_fall && bit_pos == POS_LAST)
			shreg <= {hold, hold}; // Frame start, lrclk falls
		else if (bclk_fall)
			shreg <= shreg << 1;
	end

endmodule

//--- logic/audio_out_top.sv
// Samples must arrive at or below the frame rate; extra samples between frames are dropped
`timescale 1ns/1ps

module audio_out_top import audio_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      adc_req,
	input  adc_code_t adc_code,
	output logic      adc_ack,
	input  gain_t     gain,
	input  logic      bypass,
	output logic      mclk,
	output logic      bclk,
	output logic      lrclk,
	output logic      sdata
);

	sample_beat_t cap_beat;  // Converted sample, one-cycle valid
	sample_beat_t gain_beat; // After gain or bypass

	// ADC handshake and code conversion
	sample_capture u_capture (
		.clk      (clk),
		.rst      (rst),
		.adc_req  (adc_req),
		.adc_code (adc_code),
		.adc_ack  (adc_ack),
		.beat     (cap_beat)
	);

	// Two-cycle gain and saturation
	gain_stage u_gain (
		.clk      (clk),
		.rst      (rst),
		.beat_in  (cap_beat),
		.gain     (gain),
		.bypass   (bypass),
		.beat_out (gain_beat)
	);

	// DAC side
	i2s_transmitter u_i2s (
		.clk   (clk),
		.rst   (rst),
		.beat  (gain_beat),
		.mclk  (mclk),
		.bclk  (bclk),
		.lrclk (lrclk),
		.sdata (sdata)
	);

endmodule

//--- testbench/audio_tb.sv
// Assumes the default clock ratios and a 4 ns clk; checks each sample two frames after its handshake
`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_tb import audio_pkg::*; ();

	localparam int CLK_NS     = 4;
	localparam int FRAME_BITS = 2 * `AUDIO_SAMPLE_W;
	localparam int FRAME_NS   = FRAME_BITS * 2 * `AUDIO_BCLK_HALF * CLK_NS;
	localparam int MCLK_RISES = FRAME_BITS * `AUDIO_BCLK_HALF / `AUDIO_MCLK_HALF;
	localparam int N_UNITY    = 8;
	localparam int N_GAIN     = 12;
	localparam int N_SAT      = 4;
	localparam int N_BYPASS   = 6;
	localparam int N_SAMPLES  = N_UNITY + N_GAIN + N_SAT + N_BYPASS;
	localparam int TIMEOUT_NS = N_SAMPLES * 3 * FRAME_NS + 20 * FRAME_NS;
	localparam int ADC_MID    = 1 << (`AUDIO_ADC_W - 1);
	localparam int PAD_SCALE  = 1 << (`AUDIO_SAMPLE_W - `AUDIO_ADC_W);
	localparam int GAIN_ONE   = 1 << `AUDIO_GAIN_FRAC;
	localparam int SAMPLE_MAX = (1 << (`AUDIO_SAMPLE_W - 1)) - 1;
	localparam int SAMPLE_MIN = -(1 << (`AUDIO_SAMPLE_W - 1));

	logic      clk;
	logic      rst;
	logic      adc_req;
	adc_code_t adc_code;
	logic      adc_ack;
	gain_t     gain;
	logic      bypass;
	logic      mclk;
	logic      bclk;
	logic      lrclk;
	logic      sdata;

	integer seed;
	int     errors;

	// I2S receiver
	sample_t left_sr;
	sample_t right_sr;
	sample_t left_word;
	sample_t right_word;
	logic    rx_lr_prev;
	int      frame_cnt;

	// Framing monitor
	logic mon_bclk;
	logic mon_mclk;
	logic mon_lr;
	logic seen_fall;
	int   bclk_rises;
	int   mclk_rises;

	audio_out_top u_dut (
		.clk      (clk),
		.rst      (rst),
		.adc_req  (adc_req),
		.adc_code (adc_code),
		.adc_ack  (adc_ack),
		.gain     (gain),
		.bypass   (bypass),
		.mclk     (mclk),
		.bclk     (bclk),
		.lrclk    (lrclk),
		.sdata    (sdata)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s expected %0d (%h) got %0d (%h)",
				$time, name, expected, expected, actual, actual);
			errors++;
		end
	endtask

	// Offset binary to signed, then Q2.8 gain with floor and clamp
	function automatic sample_t expected_sample(input adc_code_t code, input gain_t g, input logic byp);
		int centered;
		int prod;
		int scaled;
		centered = (int'(code) - ADC_MID) * PAD_SCALE;
		if (byp)
			return sample_t'(centered);
		prod   = centered * int'(g);
		scaled = prod / GAIN_ONE;
		if (prod < 0 && prod % GAIN_ONE != 0)
			scaled = scaled - 1; // Division truncates, floor wanted
		if (scaled > SAMPLE_MAX)
			scaled = SAMPLE_MAX;
		else if (scaled < SAMPLE_MIN)
			scaled = SAMPLE_MIN;
		return sample_t'(scaled);
	endfunction

	task automatic check_idle_outputs();
		check_bit("adc_ack", 1'b0, adc_ack);
		check_bit("mclk", 1'b0, mclk);
		check_bit("bclk", 1'b0, bclk);
		check_bit("lrclk", 1'b0, lrclk);
		check_bit("sdata", 1'b0, sdata);
	endtask

	// Four-phase req/ack with a random hold of req
	task automatic handshake(input adc_code_t code);
		int hold_cycles;
		hold_cycles = $unsigned($random(seed)) % 3;
		@(posedge clk);
		#1;
		adc_code = code;
		adc_req  = 1'b1;
		check_bit("adc_ack", 1'b0, adc_ack);
		@(posedge clk);
		#1;
		check_bit("adc_ack", 1'b1, adc_ack); // One cycle after req
		repeat (hold_cycles) begin
			@(posedge clk);
			#1;
			check_bit("adc_ack", 1'b1, adc_ack);
		end
		adc_req = 1'b0;
		@(posedge clk);
		#1;
		check_bit("adc_ack", 1'b0, adc_ack);
	endtask

	task automatic run_sample(input adc_code_t code, input gain_t g, input logic byp,
			input sample_t expected);
		int start_frame;
		@(posedge clk);
		#1;
		gain   = g;
		bypass = byp;
		handshake(code);
		repeat (2) @(negedge lrclk);
		start_frame = frame_cnt;
		// This frame is complete one bclk into the frame after it
		wait (frame_cnt >= start_frame + 2);
		check_sample("left slot", expected, left_word);
		check_sample("right slot", expected, right_word);
	endtask

	// Channel of each bit follows lrclk one bclk earlier
	always @(posedge bclk) begin
		if (rx_lr_prev)
			right_sr = {right_sr[`AUDIO_SAMPLE_W-2:0], sdata};
		else
			left_sr = {left_sr[`AUDIO_SAMPLE_W-2:0], sdata};
		if (rx_lr_prev && !lrclk) begin
			left_word  = left_sr;
			right_word = right_sr;
			frame_cnt  = frame_cnt + 1;
		end
		rx_lr_prev = lrclk;
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (bclk && !mon_bclk)
				bclk_rises = bclk_rises + 1;
			if (mclk && !mon_mclk)
				mclk_rises = mclk_rises + 1;
			if (lrclk != mon_lr) begin
				check_bit("bclk at lrclk edge", 1'b0, bclk);
				if (!lrclk) begin
					if (seen_fall && bclk_rises != FRAME_BITS) begin
						$display("Framing error at %0t: %0d bclk rises in a frame, %0d expected",
							$time, bclk_rises, FRAME_BITS);
						errors++;
					end
					if (seen_fall && mclk_rises != MCLK_RISES) begin
						$display("Clock error at %0t: %0d mclk rises in a frame, %0d expected",
							$time, mclk_rises, MCLK_RISES);
						errors++;
					end
					seen_fall  = 1'b1;
					bclk_rises = 0;
					mclk_rises = 0;
				end
			end
			mon_bclk = bclk;
			mon_mclk = mclk;
			mon_lr   = lrclk;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Test failures found");
		$finish;
	end

	initial begin
		adc_code_t code;
		gain_t     g;
		adc_code_t sat_codes [4];
		clk        = 1'b0;
		rst        = 1'b1;
		adc_req    = 1'b0;
		adc_code   = '0;
		gain       = gain_t'(GAIN_ONE);
		bypass     = 1'b0;
		seed       = 32'ha4f27ba1;
		errors     = 0;
		left_sr    = '0;
		right_sr   = '0;
		left_word  = '0;
		right_word = '0;
		rx_lr_prev = 1'b0;
		frame_cnt  = 0;
		mon_bclk   = 1'b0;
		mon_mclk   = 1'b0;
		mon_lr     = 1'b0;
		seen_fall  = 1'b0;
		bclk_rises = 0;
		mclk_rises = 0;
		sat_codes  = '{12'h000, 12'h001, 12'hffe, 12'hfff};

		@(posedge clk);
		#1;
		check_idle_outputs();
		@(posedge clk);
		#1;
		check_idle_outputs();
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_idle_outputs(); // First cycle out of reset

		// Unity gain with the corner codes first
		run_sample(12'h000, gain_t'(GAIN_ONE), 1'b0,
			expected_sample(12'h000, gain_t'(GAIN_ONE), 1'b0));
		run_sample(12'h800, gain_t'(GAIN_ONE), 1'b0,
			expected_sample(12'h800, gain_t'(GAIN_ONE), 1'b0));
		run_sample(12'hfff, gain_t'(GAIN_ONE), 1'b0,
			expected_sample(12'hfff, gain_t'(GAIN_ONE), 1'b0));
		for (int i = 3; i < N_UNITY; i++) begin
			code = adc_code_t'($random(seed));
			run_sample(code, gain_t'(GAIN_ONE), 1'b0,
				expected_sample(code, gain_t'(GAIN_ONE), 1'b0));
		end

		for (int i = 0; i < N_GAIN; i++) begin
			code = adc_code_t'($random(seed));
			g    = gain_t'($random(seed));
			run_sample(code, g, 1'b0, expected_sample(code, g, 1'b0));
		end

		// Gain of at least 2 drives the extremes into the rails
		for (int i = 0; i < N_SAT; i++) begin
			g = gain_t'(2 * GAIN_ONE + $unsigned($random(seed)) % (2 * GAIN_ONE));
			run_sample(sat_codes[i], g, 1'b0,
				sat_codes[i][`AUDIO_ADC_W-1] ? sample_t'(SAMPLE_MAX) : sample_t'(SAMPLE_MIN));
		end

		for (int i = 0; i < N_BYPASS; i++) begin
			code = adc_code_t'($random(seed));
			g    = gain_t'($random(seed));
			run_sample(code, g, 1'b1, expected_sample(code, g, 1'b1));
		end

		$display("Checked %0d samples, %0d errors", N_SAMPLES, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+logic
logic/audio_pkg.sv
logic/sample_capture.sv
logic/gain_stage.sv
logic/i2s_transmitter.sv
logic/audio_out_top.sv
testbench/audio_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary -f vlog.f --top-module audio_tb -Mdir obj_dir -o audio_sim || exit 1
out="$(./obj_dir/audio_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'All tests passed!' && echo "PASS" || { echo "FAIL"; exit 1; }
